// File: Makefile
TOP := tb_cache_memctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

// File: hw/cache_access_pkg.sv
// Cache access package
// Directory entry layout
// Request structs for directory lookup, update and refill
// Request structs for data read, request write and refill write
`default_nettype none

package cache_access_pkg;

    import cache_geom_pkg::*;

    // One way of one set in the tag directory
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    // Tag match request
    typedef struct packed {
        set_t set;
        tag_t tag;
    } dir_lookup_t;

    // Entry write, shared by update and refill
    typedef struct packed {
        set_t       set;
        way_vec_t   way;
        dir_entry_t entry;
    } dir_write_t;

    // Single word read, way comes from the directory
    typedef struct packed {
        set_t      set;
        word_idx_t word;
    } data_read_t;

    // Partial word write into the hit way
    typedef struct packed {
        set_t       set;
        word_idx_t  word;
        data_word_t data;
        be_t        be;
    } data_req_write_t;

    // Full word write into an explicit way
    typedef struct packed {
        set_t       set;
        way_vec_t   way;
        word_idx_t  word;
        data_word_t data;
    } data_refill_t;

endpackage

`default_nettype wire

// File: hw/cache_data_array.sv
// Data array
// Write source and way selection for refill and request writes
// Byte-lane RAMs, one per way and byte
// Read word assembly and hit way select
`timescale 1ns/100ps
`default_nettype none

module cache_data_array (
    input  logic                              clk_i,
    input  cache_geom_pkg::way_vec_t          hit_way_i,
    input  logic                              read_i,
    input  cache_access_pkg::data_read_t      read_req_i,
    input  logic                              req_write_i,
    input  cache_access_pkg::data_req_write_t req_write_req_i,
    input  logic                              refill_i,
    input  cache_access_pkg::data_refill_t    refill_req_i,
    output cache_geom_pkg::data_word_t        read_data_o
);

    import cache_geom_pkg::*;

    typedef logic [7:0] lane_t;

    data_addr_t                            ram_addr;
    way_vec_t                              wr_way;
    be_t                                   wr_be;
    data_word_t                            wr_data;
    logic                                  rd_en;
    logic [WAYS-1:0][WORD_BYTES-1:0]       lane_cs;
    logic [WAYS-1:0][WORD_BYTES-1:0]       lane_we;
    data_word_t [WAYS-1:0]                 way_word;

    function automatic data_addr_t line_addr(input set_t set, input word_idx_t word);
        return data_addr_t'(int'(set) * LINE_WORDS + int'(word));
    endfunction

    // Refill wins over request write, which wins over read
    always_comb begin
        ram_addr = line_addr(read_req_i.set, read_req_i.word);
        wr_way   = '0;
        wr_be    = '0;
        wr_data  = '0;
        rd_en    = 1'b0;
        if (refill_i) begin
            ram_addr = line_addr(refill_req_i.set, refill_req_i.word);
            wr_way   = refill_req_i.way;
            wr_be    = '1;
            wr_data  = refill_req_i.data;
        end else if (req_write_i) begin
            ram_addr = line_addr(req_write_req_i.set, req_write_req_i.word);
            // Zero hit vector on a miss, so nothing is written
            wr_way   = hit_way_i;
            wr_be    = req_write_req_i.be;
            wr_data  = req_write_req_i.data;
        end else if (read_i) begin
            rd_en = 1'b1;
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        for (genvar b = 0; b < WORD_BYTES; b++) begin : g_lane
            assign lane_we[w][b] = wr_way[w] & wr_be[b];
            // Reads open every lane of every way
            assign lane_cs[w][b] = lane_we[w][b] | rd_en;

            cache_sram #(
                .DEPTH   (SETS * LINE_WORDS),
                .entry_t (lane_t)
            ) i_data_sram (
                .clk_i   (clk_i),
                .cs_i    (lane_cs[w][b]),
                .we_i    (lane_we[w][b]),
                .addr_i  (ram_addr),
                .wdata_i (wr_data[8*b +: 8]),
                .rdata_o (way_word[w][8*b +: 8])
            );
        end
    end

    // Word of the hit way, zero on a miss
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            read_data_o = read_data_o | (way_word[w] & {WORD_WIDTH{hit_way_i[w]}});
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_dir_array.sv
// Tag directory
// Access arbitration between init, lookup, refill and update
// One directory RAM per way
// Registered lookup tag, per-way tag compare, hit tag and dirty select
`timescale 1ns/100ps
`default_nettype none

module cache_dir_array (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          init_active_i,
    input  cache_geom_pkg::set_t          init_set_i,
    input  logic                          lookup_i,
    input  cache_access_pkg::dir_lookup_t lookup_req_i,
    input  logic                          update_i,
    input  cache_access_pkg::dir_write_t  update_req_i,
    input  logic                          refill_i,
    input  cache_access_pkg::dir_write_t  refill_req_i,
    output cache_geom_pkg::way_vec_t      hit_way_o,
    output cache_geom_pkg::tag_t          hit_tag_o,
    output logic                          hit_dirty_o
);

    import cache_geom_pkg::*;
    import cache_access_pkg::*;

    set_t       dir_addr;
    way_vec_t   dir_cs;
    way_vec_t   dir_we;
    dir_entry_t dir_wentry;
    dir_entry_t dir_rentry [WAYS];

    logic       lookup_valid_q;
    tag_t       lookup_tag_q;
    way_vec_t   tag_match;
    way_vec_t   hit_way;

    // Priority: init, lookup, refill, update
    always_comb begin
        dir_addr   = '0;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '0;
        if (init_active_i) begin
            dir_addr = init_set_i;
            dir_cs   = '1;
            dir_we   = '1;
        end else if (lookup_i) begin
            dir_addr = lookup_req_i.set;
            dir_cs   = '1;
        end else if (refill_i) begin
            dir_addr   = refill_req_i.set;
            dir_cs     = refill_req_i.way;
            dir_we     = refill_req_i.way;
            dir_wentry = refill_req_i.entry;
        end else if (update_i) begin
            dir_addr   = update_req_i.set;
            dir_cs     = update_req_i.way;
            dir_we     = update_req_i.way;
            dir_wentry = update_req_i.entry;
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_sram #(
            .DEPTH   (SETS),
            .entry_t (dir_entry_t)
        ) i_dir_sram (
            .clk_i   (clk_i),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .rdata_o (dir_rentry[w])
        );

        assign tag_match[w] = dir_rentry[w].valid && (dir_rentry[w].tag == lookup_tag_q);
    end

    // Marks the cycle that follows an accepted lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_i && !init_active_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lookup_i) begin
            lookup_tag_q <= lookup_req_i.tag;
        end
    end

    // No lookup last cycle means no way is selected
    assign hit_way = lookup_valid_q ? tag_match : '0;

    // AND-OR select, hit vector is one-hot or zero
    always_comb begin
        hit_tag_o   = '0;
        hit_dirty_o = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            hit_tag_o   = hit_tag_o | (dir_rentry[w].tag & {TAG_WIDTH{hit_way[w]}});
            hit_dirty_o = hit_dirty_o | (dir_rentry[w].dirty & hit_way[w]);
        end
    end

    assign hit_way_o = hit_way;

endmodule

`default_nettype wire

// File: hw/cache_dir_init.sv
// Directory initialisation sequencer
// Sweeps every set once after reset so that all ways get cleared,
// then drops the active flag for good
`timescale 1ns/100ps
`default_nettype none

module cache_dir_init (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    output logic                 init_active_o,
    output cache_geom_pkg::set_t init_set_o
);

    import cache_geom_pkg::*;

    logic active_q;
    set_t set_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b1;
            set_q    <= '0;
        end else if (active_q) begin
            set_q <= set_t'(set_q + 1'b1);
            // Last set written in this cycle
            if (set_q == set_t'(SETS - 1)) begin
                active_q <= 1'b0;
            end
        end
    end

    assign init_active_o = active_q;
    assign init_set_o    = set_q;

endmodule

`default_nettype wire

// File: hw/cache_geom_pkg.sv
// Cache geometry package
// Set, way, line and word dimensions of the data cache
// Index, tag, way vector, data word and data RAM address types
`default_nettype none

package cache_geom_pkg;

    // Cache organisation
    localparam int unsigned SETS       = 64;
    localparam int unsigned WAYS       = 4;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned WORD_WIDTH = 32;
    localparam int unsigned WORD_BYTES = WORD_WIDTH / 8;
    localparam int unsigned TAG_WIDTH  = 20;

    // Derived index widths
    localparam int unsigned SET_WIDTH       = $clog2(SETS);
    localparam int unsigned WORD_IDX_WIDTH  = $clog2(LINE_WORDS);
    localparam int unsigned DATA_ADDR_WIDTH = SET_WIDTH + WORD_IDX_WIDTH;

    typedef logic [SET_WIDTH-1:0]       set_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;

    // One-hot, or zero when nothing matches
    typedef logic [WAYS-1:0]            way_vec_t;

    typedef logic [WORD_IDX_WIDTH-1:0]  word_idx_t;
    typedef logic [WORD_WIDTH-1:0]      data_word_t;
    typedef logic [WORD_BYTES-1:0]      be_t;

    // Row of the data RAMs, set-major
    typedef logic [DATA_ADDR_WIDTH-1:0] data_addr_t;

endpackage

`default_nettype wire

// File: hw/cache_memctrl.sv
// Cache memory controller top level
// Directory init sequencer, tag directory and data array
// Ready level and strobe qualification for the data side
`timescale 1ns/100ps
`default_nettype none

module cache_memctrl (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    // Directory side
    input  logic                              dir_lookup_i,
    input  cache_access_pkg::dir_lookup_t     dir_lookup_req_i,
    input  logic                              dir_update_i,
    input  cache_access_pkg::dir_write_t      dir_update_req_i,
    input  logic                              dir_refill_i,
    input  cache_access_pkg::dir_write_t      dir_refill_req_i,
    output cache_geom_pkg::way_vec_t          dir_hit_way_o,
    output cache_geom_pkg::tag_t              dir_hit_tag_o,
    output logic                              dir_hit_dirty_o,

    // Data side
    input  logic                              data_read_i,
    input  cache_access_pkg::data_read_t      data_read_req_i,
    input  logic                              data_req_write_i,
    input  cache_access_pkg::data_req_write_t data_req_write_req_i,
    input  logic                              data_refill_i,
    input  cache_access_pkg::data_refill_t    data_refill_req_i,
    output cache_geom_pkg::data_word_t        data_read_data_o,

    output logic                              ready_o
);

    import cache_geom_pkg::*;

    logic     init_active;
    set_t     init_set;
    way_vec_t hit_way;
    logic     ready;

    cache_dir_init i_dir_init (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .init_active_o (init_active),
        .init_set_o    (init_set)
    );

    assign ready = ~init_active;

    // Directory strobes are overridden by init inside the directory
    cache_dir_array i_dir_array (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .init_active_i (init_active),
        .init_set_i    (init_set),
        .lookup_i      (dir_lookup_i),
        .lookup_req_i  (dir_lookup_req_i),
        .update_i      (dir_update_i),
        .update_req_i  (dir_update_req_i),
        .refill_i      (dir_refill_i),
        .refill_req_i  (dir_refill_req_i),
        .hit_way_o     (hit_way),
        .hit_tag_o     (dir_hit_tag_o),
        .hit_dirty_o   (dir_hit_dirty_o)
    );

    // Data strobes only count once the directory is ready
    cache_data_array i_data_array (
        .clk_i           (clk_i),
        .hit_way_i       (hit_way),
        .read_i          (data_read_i & ready),
        .read_req_i      (data_read_req_i),
        .req_write_i     (data_req_write_i & ready),
        .req_write_req_i (data_req_write_req_i),
        .refill_i        (data_refill_i & ready),
        .refill_req_i    (data_refill_req_i),
        .read_data_o     (data_read_data_o)
    );

    assign dir_hit_way_o = hit_way;
    assign ready_o       = ready;

endmodule

`default_nettype wire

// File: hw/cache_sram.sv
// Single-port synchronous RAM
// Generic payload type, write on chip select with write enable,
// registered read data that holds between reads
`timescale 1ns/100ps
`default_nettype none

module cache_sram #(
    parameter int unsigned DEPTH = 64,
    parameter type entry_t = logic [7:0]
) (
    input  logic                     clk_i,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o
);

    entry_t mem_q [DEPTH];
    entry_t rdata_q;

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_q <= mem_q[addr_i];
            end
        end
    end

    // Read port keeps the last word read
    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: tb.f
hw/cache_geom_pkg.sv
hw/cache_access_pkg.sv
hw/cache_sram.sv
hw/cache_dir_init.sv
hw/cache_dir_array.sv
hw/cache_data_array.sv
hw/cache_memctrl.sv
verification/cache_memctrl_sva.sv
verification/tb_cache_memctrl.sv

// File: verification/cache_memctrl_sva.sv
// Protocol checks bound to the cache memory controller
// One directory strobe and one data strobe per cycle at most
// Ready level stays high once raised, no strobes before ready
`timescale 1ns/100ps
`default_nettype none

module cache_memctrl_sva (
    input logic clk_i,
    input logic rst_ni,
    input logic dir_lookup_i,
    input logic dir_update_i,
    input logic dir_refill_i,
    input logic data_read_i,
    input logic data_req_write_i,
    input logic data_refill_i,
    input logic ready_o
);

    logic any_strobe;

    assign any_strobe = dir_lookup_i | dir_update_i | dir_refill_i
                      | data_read_i | data_req_write_i | data_refill_i;

    dir_strobe_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dir_lookup_i, dir_update_i, dir_refill_i})
    ) else $error("more than one directory strobe in a cycle");

    data_strobe_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({data_read_i, data_req_write_i, data_refill_i})
    ) else $error("more than one data strobe in a cycle");

    ready_stays_high: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ready_o |=> ready_o
    ) else $error("ready fell after it had risen");

    no_strobe_before_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !ready_o |-> !any_strobe
    ) else $error("strobe issued while not ready");

endmodule

bind cache_memctrl cache_memctrl_sva i_memctrl_sva (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dir_lookup_i     (dir_lookup_i),
    .dir_update_i     (dir_update_i),
    .dir_refill_i     (dir_refill_i),
    .data_read_i      (data_read_i),
    .data_req_write_i (data_req_write_i),
    .data_refill_i    (data_refill_i),
    .ready_o          (ready_o)
);

`default_nettype wire

// File: verification/tb_cache_memctrl.sv
// Testbench for the cache memory controller
// Clock, reset, directory and data reference model
// Directed and random tests for init, lookup, update, refill and data access
// Watchdog and closing report
`timescale 1ns/100ps
`default_nettype none

module tb_cache_memctrl;

    import cache_geom_pkg::*;
    import cache_access_pkg::*;

    localparam int unsigned SEED       = 25780;
    localparam int unsigned CLK_PERIOD = 40;
    localparam int unsigned N_ITER     = 24;
    // Reset, init sweep and first lookups, then cycles per iteration of tests 2 to 5
    localparam int unsigned RUN_CYCLES = 3 + 4 * SETS + 71 * N_ITER;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    logic lookup_stb, update_stb, refill_stb;
    dir_lookup_t lookup_req;
    dir_write_t update_req, refill_req;
    logic read_stb, wr_stb, dfill_stb;
    data_read_t read_req;
    data_req_write_t wr_req;
    data_refill_t dfill_req;
    way_vec_t hit_way;
    tag_t hit_tag;
    logic hit_dirty;
    data_word_t read_data;
    logic ready;

    dir_entry_t dir_model [int];
    data_word_t data_model [int];
    int checks = 0;
    int errors = 0;

    cache_memctrl i_cache_memctrl (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .dir_lookup_i         (lookup_stb),
        .dir_lookup_req_i     (lookup_req),
        .dir_update_i         (update_stb),
        .dir_update_req_i     (update_req),
        .dir_refill_i         (refill_stb),
        .dir_refill_req_i     (refill_req),
        .dir_hit_way_o        (hit_way),
        .dir_hit_tag_o        (hit_tag),
        .dir_hit_dirty_o      (hit_dirty),
        .data_read_i          (read_stb),
        .data_read_req_i      (read_req),
        .data_req_write_i     (wr_stb),
        .data_req_write_req_i (wr_req),
        .data_refill_i        (dfill_stb),
        .data_refill_req_i    (dfill_req),
        .data_read_data_o     (read_data),
        .ready_o              (ready)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic dir_entry_t dir_get(input set_t s, input int w);
        return dir_model.exists(int'(s) * WAYS + w) ? dir_model[int'(s) * WAYS + w] : '0;
    endfunction

    function automatic int data_key(input set_t s, input word_idx_t wd, input int w);
        return (int'(s) * LINE_WORDS + int'(wd)) * WAYS + w;
    endfunction

    // Low tag bits carry the way, so ways of a set never share a tag
    function automatic tag_t make_tag(input int w);
        tag_t r;
        r = tag_t'($urandom);
        return {r[TAG_WIDTH-1:2], 2'(w)};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic dir_write(input logic is_refill, input set_t s, input int w,
                             input dir_entry_t e);
        @(posedge clk_i);
        if (is_refill) begin
            refill_stb <= 1'b1;
            refill_req <= '{set: s, way: way_vec_t'(1 << w), entry: e};
        end else begin
            update_stb <= 1'b1;
            update_req <= '{set: s, way: way_vec_t'(1 << w), entry: e};
        end
        @(posedge clk_i);
        refill_stb <= 1'b0;
        update_stb <= 1'b0;
        dir_model[int'(s) * WAYS + w] = e;
    endtask

    task automatic data_fill(input set_t s, input int w, input word_idx_t wd,
                             input data_word_t d);
        @(posedge clk_i);
        dfill_stb <= 1'b1;
        dfill_req <= '{set: s, way: way_vec_t'(1 << w), word: wd, data: d};
        @(posedge clk_i);
        dfill_stb <= 1'b0;
        data_model[data_key(s, wd, w)] = d;
    endtask

    // Lookup with an optional read and an optional request write one cycle later
    task automatic access(input set_t s, input tag_t t, input logic do_read,
                          input word_idx_t wd, input logic do_write,
                          input data_word_t d, input be_t be);
        way_vec_t exp_way;
        tag_t exp_tag;
        logic exp_dirty;
        data_word_t exp_data;
        dir_entry_t e;
        int hit_idx;
        exp_way = '0;
        exp_tag = '0;
        exp_dirty = 1'b0;
        exp_data = '0;
        hit_idx = -1;
        for (int w = 0; w < WAYS; w++) begin
            e = dir_get(s, w);
            if (e.valid && e.tag == t) begin
                exp_way[w] = 1'b1;
                exp_tag = e.tag;
                exp_dirty = e.dirty;
                hit_idx = w;
            end
        end
        if (hit_idx >= 0 && data_model.exists(data_key(s, wd, hit_idx)))
            exp_data = data_model[data_key(s, wd, hit_idx)];
        @(posedge clk_i);
        lookup_stb <= 1'b1;
        lookup_req <= '{set: s, tag: t};
        read_stb <= do_read;
        read_req <= '{set: s, word: wd};
        @(posedge clk_i);
        lookup_stb <= 1'b0;
        read_stb <= 1'b0;
        wr_stb <= do_write;
        wr_req <= '{set: s, word: wd, data: d, be: be};
        @(negedge clk_i);
        compare_value("hit way", 32'(hit_way), 32'(exp_way));
        compare_value("hit tag", 32'(hit_tag), 32'(exp_tag));
        compare_value("hit dirty", 32'(hit_dirty), 32'(exp_dirty));
        if (do_read)
            compare_value("read data", read_data, exp_data);
        @(posedge clk_i);
        wr_stb <= 1'b0;
        if (do_write && hit_idx >= 0) begin
            for (int b = 0; b < WORD_BYTES; b++)
                if (be[b])
                    exp_data[8*b +: 8] = d[8*b +: 8];
            data_model[data_key(s, wd, hit_idx)] = exp_data;
        end
    endtask

    task automatic fill_line(input set_t s, input int w, input tag_t t);
        dir_write(1'b1, s, w, '{valid: 1'b1, dirty: 1'($urandom), tag: t});
        for (int wd = 0; wd < LINE_WORDS; wd++)
            data_fill(s, w, word_idx_t'(wd), data_word_t'($urandom));
    endtask

    task automatic report(input int n, input string name, input int err_before);
        $display("test %0d %s done, %0d errors", n, name, errors - err_before);
    endtask

    initial begin
        int e0;
        int cycles;
        set_t s;
        int w;
        tag_t t;
        void'($urandom(SEED));
        {lookup_stb, update_stb, refill_stb, read_stb, wr_stb, dfill_stb} = '0;
        lookup_req = '0;
        update_req = '0;
        refill_req = '0;
        read_req = '0;
        wr_req = '0;
        dfill_req = '0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        e0 = errors;
        @(negedge clk_i);
        compare_value("ready after reset", 32'(ready), 32'd0);
        cycles = 0;
        while (!ready && cycles < SETS + 10) begin
            @(posedge clk_i);
            cycles++;
            @(negedge clk_i);
        end
        compare_value("ready latency", cycles, SETS);
        for (int i = 0; i < SETS; i++)
            access(set_t'(i), tag_t'($urandom), 1'b0, '0, 1'b0, '0, '0);
        report(1, "init", e0);

        e0 = errors;
        for (int i = 0; i < N_ITER; i++) begin
            s = set_t'($urandom);
            w = $urandom % WAYS;
            t = make_tag(w);
            dir_write(1'b1, s, w, '{valid: 1'b1, dirty: 1'($urandom), tag: t});
            access(s, t, 1'b0, '0, 1'b0, '0, '0);
            access(s, t ^ tag_t'(1 << 19), 1'b0, '0, 1'b0, '0, '0);
        end
        report(2, "directory refill", e0);

        e0 = errors;
        for (int i = 0; i < N_ITER; i++) begin
            s = set_t'($urandom);
            w = $urandom % WAYS;
            t = make_tag(w);
            dir_write(1'b1, s, w, '{valid: 1'b1, dirty: 1'b0, tag: t});
            dir_write(1'b0, s, w, '{valid: 1'b1, dirty: 1'b1, tag: t});
            access(s, t, 1'b0, '0, 1'b0, '0, '0);
            dir_write(1'b0, s, w, '{valid: 1'b0, dirty: 1'b0, tag: t});
            access(s, t, 1'b0, '0, 1'b0, '0, '0);
        end
        report(3, "directory update", e0);

        e0 = errors;
        for (int i = 0; i < N_ITER; i++) begin
            s = set_t'($urandom);
            w = $urandom % WAYS;
            t = make_tag(w);
            fill_line(s, w, t);
            access(s, t, 1'b1, word_idx_t'($urandom), 1'b0, '0, '0);
            access(s, t ^ tag_t'(1 << 19), 1'b1, word_idx_t'($urandom), 1'b0, '0, '0);
        end
        report(4, "data refill and read", e0);

        e0 = errors;
        for (int i = 0; i < N_ITER; i++) begin
            word_idx_t wd;
            int w2;
            tag_t t2;
            s = set_t'($urandom);
            w = $urandom % WAYS;
            t = make_tag(w);
            w2 = (w + 1) % WAYS;
            t2 = make_tag(w2);
            wd = word_idx_t'($urandom);
            fill_line(s, w, t);
            // Neighbour way of the same set keeps its data
            fill_line(s, w2, t2);
            access(s, t, 1'b0, wd, 1'b1, data_word_t'($urandom), be_t'($urandom));
            access(s, t, 1'b1, wd, 1'b0, '0, '0);
            // A write after a miss leaves the line alone
            access(s, t ^ tag_t'(1 << 19), 1'b0, wd, 1'b1, data_word_t'($urandom), '1);
            access(s, t, 1'b1, wd, 1'b0, '0, '0);
            access(s, t2, 1'b1, wd, 1'b0, '0, '0);
        end
        report(5, "request write", e0);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
